// File: mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data path width
`define MIPS_XLEN 32

// register file geometry
`define MIPS_REG_AW 5
`define MIPS_REG_COUNT 32

// shift amount field, also the low bits used by the variable shifts
`define MIPS_SHAMT_W 5

`endif

// File: mips_pkg.sv
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

	// primary opcode, only the kept subset
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_addi    = 6'h08,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f
	} opcode_e;

	// funct field of special
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_sra  = 6'h03,
		fn_sllv = 6'h04,
		fn_srlv = 6'h06,
		fn_srav = 6'h07,
		fn_add  = 6'h20,
		fn_addu = 6'h21,
		fn_sub  = 6'h22,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_nop  = 4'd0,
		alu_or   = 4'd1,
		alu_and  = 4'd2,
		alu_xor  = 4'd3,
		alu_nor  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_add  = 4'd8, // traps on overflow
		alu_addu = 4'd9,
		alu_sub  = 4'd10, // traps on overflow
		alu_subu = 4'd11,
		alu_slt  = 4'd12,
		alu_sltu = 4'd13
	} alu_op_e;

	typedef enum logic [1:0] {
		sel_none  = 2'd0,
		sel_logic = 2'd1,
		sel_shift = 2'd2,
		sel_arith = 2'd3
	} alu_sel_e;

	typedef struct packed {
		opcode_e opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [`MIPS_SHAMT_W-1:0] shamt;
		funct_e funct;
	} r_fields_t;

	typedef struct packed {
		opcode_e opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [15:0] imm16;
	} i_fields_t;

	// same 32 bits, register or immediate layout
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_u;

endpackage

`default_nettype wire

// File: mips_if.sv
`timescale 1ns/1ps
`default_nettype none

// one decoded instruction, decode to execute
interface issue_if;
	logic valid;
	mips_pkg::alu_op_e op;
	mips_pkg::alu_sel_e sel;
	mips_pkg::word_t operand_a;
	mips_pkg::word_t operand_b;
	mips_pkg::reg_addr_t dest;
	logic write_en; // low for reg 0 and unsupported words

	modport issuer (
		output valid, op, sel, operand_a, operand_b, dest, write_en
	);

	modport executor (
		input valid, op, sel, operand_a, operand_b, dest, write_en
	);
endinterface

// two read ports of the register file, data is combinational
interface reg_read_if;
	mips_pkg::reg_addr_t addr_a;
	mips_pkg::reg_addr_t addr_b;
	mips_pkg::word_t data_a;
	mips_pkg::word_t data_b;

	modport reader (
		output addr_a, addr_b,
		input data_a, data_b
	);

	modport file (
		input addr_a, addr_b,
		output data_a, data_b
	);
endinterface

`default_nettype wire

// File: mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_decode (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic inst_valid_i,
	input mips_pkg::instr_u inst_i,
	reg_read_if.reader rd_port,
	input wire logic ex_fwd_valid_i,
	input mips_pkg::reg_addr_t ex_fwd_addr_i,
	input mips_pkg::word_t ex_fwd_data_i,
	input wire logic wb_valid_i,
	input mips_pkg::reg_addr_t wb_addr_i,
	input mips_pkg::word_t wb_data_i,
	issue_if.issuer issue
);

	mips_pkg::alu_op_e dec_op;
	mips_pkg::reg_addr_t dec_dest;
	logic dec_we;
	logic read_a; // else operand_a comes from imm_a
	logic read_b;
	mips_pkg::word_t imm_a;
	mips_pkg::word_t imm_b;
	mips_pkg::word_t operand_a_d;
	mips_pkg::word_t operand_b_d;
	mips_pkg::word_t zext_imm;
	mips_pkg::word_t sext_imm;

	assign zext_imm = {{(`MIPS_XLEN-16){1'b0}}, inst_i.i_fields.imm16};
	assign sext_imm = {{(`MIPS_XLEN-16){inst_i.i_fields.imm16[15]}}, inst_i.i_fields.imm16};

	assign rd_port.addr_a = inst_i.r_fields.rs;
	assign rd_port.addr_b = inst_i.r_fields.rt;

	function automatic mips_pkg::alu_sel_e sel_of(input mips_pkg::alu_op_e op);
		case (op)
			mips_pkg::alu_or, mips_pkg::alu_and,
			mips_pkg::alu_xor, mips_pkg::alu_nor: return mips_pkg::sel_logic;
			mips_pkg::alu_sll, mips_pkg::alu_srl,
			mips_pkg::alu_sra: return mips_pkg::sel_shift;
			mips_pkg::alu_nop: return mips_pkg::sel_none;
			default: return mips_pkg::sel_arith;
		endcase
	endfunction

	// youngest result in flight wins
	function automatic mips_pkg::word_t fwd_pick(input mips_pkg::reg_addr_t addr,
			input mips_pkg::word_t rf_data);
		if (ex_fwd_valid_i && ex_fwd_addr_i == addr) begin
			return ex_fwd_data_i;
		end
		if (wb_valid_i && wb_addr_i == addr) begin
			return wb_data_i;
		end
		return rf_data;
	endfunction

	always_comb begin
		dec_op = mips_pkg::alu_nop;
		dec_dest = inst_i.i_fields.rt;
		read_a = 1'b1;
		read_b = 1'b0;
		imm_a = '0;
		imm_b = zext_imm;
		case (inst_i.r_fields.opcode)
			mips_pkg::op_special: begin
				dec_dest = inst_i.r_fields.rd;
				read_b = 1'b1;
				case (inst_i.r_fields.funct)
					mips_pkg::fn_sll, mips_pkg::fn_sllv: dec_op = mips_pkg::alu_sll;
					mips_pkg::fn_srl, mips_pkg::fn_srlv: dec_op = mips_pkg::alu_srl;
					mips_pkg::fn_sra, mips_pkg::fn_srav: dec_op = mips_pkg::alu_sra;
					mips_pkg::fn_add: dec_op = mips_pkg::alu_add;
					mips_pkg::fn_addu: dec_op = mips_pkg::alu_addu;
					mips_pkg::fn_sub: dec_op = mips_pkg::alu_sub;
					mips_pkg::fn_subu: dec_op = mips_pkg::alu_subu;
					mips_pkg::fn_and: dec_op = mips_pkg::alu_and;
					mips_pkg::fn_or: dec_op = mips_pkg::alu_or;
					mips_pkg::fn_xor: dec_op = mips_pkg::alu_xor;
					mips_pkg::fn_nor: dec_op = mips_pkg::alu_nor;
					mips_pkg::fn_slt: dec_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu: dec_op = mips_pkg::alu_sltu;
					default: dec_op = mips_pkg::alu_nop;
				endcase
				// fixed shifts take the amount from shamt
				if (inst_i.r_fields.funct inside {mips_pkg::fn_sll, mips_pkg::fn_srl,
						mips_pkg::fn_sra}) begin
					read_a = 1'b0;
					imm_a = {{(`MIPS_XLEN-`MIPS_SHAMT_W){1'b0}}, inst_i.r_fields.shamt};
				end
			end
			mips_pkg::op_ori: dec_op = mips_pkg::alu_or;
			mips_pkg::op_andi: dec_op = mips_pkg::alu_and;
			mips_pkg::op_xori: dec_op = mips_pkg::alu_xor;
			mips_pkg::op_lui: begin
				dec_op = mips_pkg::alu_or;
				read_a = 1'b0; // rs ignored, or with zero
				imm_b = {inst_i.i_fields.imm16, {(`MIPS_XLEN-16){1'b0}}};
			end
			mips_pkg::op_addi: begin
				dec_op = mips_pkg::alu_add;
				imm_b = sext_imm;
			end
			mips_pkg::op_addiu: begin
				dec_op = mips_pkg::alu_addu;
				imm_b = sext_imm;
			end
			mips_pkg::op_slti: begin
				dec_op = mips_pkg::alu_slt;
				imm_b = sext_imm;
			end
			mips_pkg::op_sltiu: begin
				dec_op = mips_pkg::alu_sltu;
				imm_b = sext_imm;
			end
			default: dec_op = mips_pkg::alu_nop;
		endcase
		dec_we = (dec_op != mips_pkg::alu_nop) && (dec_dest != '0);
	end

	always_comb begin
		operand_a_d = read_a ? fwd_pick(rd_port.addr_a, rd_port.data_a) : imm_a;
		operand_b_d = read_b ? fwd_pick(rd_port.addr_b, rd_port.data_b) : imm_b;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			issue.valid <= 1'b0;
			issue.write_en <= 1'b0;
		end else begin
			issue.valid <= inst_valid_i;
			issue.write_en <= inst_valid_i && dec_we;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			issue.op <= dec_op;
			issue.sel <= sel_of(dec_op);
			issue.operand_a <= operand_a_d;
			issue.operand_b <= operand_b_d;
			issue.dest <= dec_dest;
		end
	end

	// a write always belongs to a live issue with a real destination
	assert property (@(posedge clk) disable iff (reset_i)
		issue.write_en |-> (issue.valid && issue.dest != '0))
		else $error("decode issued a write to register 0");

endmodule

`default_nettype wire

// File: mips_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_execute (
	input wire logic clk,
	input wire logic reset_i,
	issue_if.executor issue,
	output logic ex_fwd_valid_o,
	output mips_pkg::reg_addr_t ex_fwd_addr_o,
	output mips_pkg::word_t ex_fwd_data_o,
	output logic wb_valid_o,
	output mips_pkg::reg_addr_t wb_addr_o,
	output mips_pkg::word_t wb_data_o
);

	logic [`MIPS_SHAMT_W-1:0] sa;
	mips_pkg::word_t sum;
	mips_pkg::word_t diff;
	mips_pkg::word_t logic_res;
	mips_pkg::word_t shift_res;
	mips_pkg::word_t arith_res;
	mips_pkg::word_t result;
	logic ovf;

	assign sa = issue.operand_a[`MIPS_SHAMT_W-1:0];
	assign sum = issue.operand_a + issue.operand_b;
	assign diff = issue.operand_a - issue.operand_b;

	always_comb begin
		case (issue.op)
			mips_pkg::alu_or: logic_res = issue.operand_a | issue.operand_b;
			mips_pkg::alu_and: logic_res = issue.operand_a & issue.operand_b;
			mips_pkg::alu_xor: logic_res = issue.operand_a ^ issue.operand_b;
			mips_pkg::alu_nor: logic_res = ~(issue.operand_a | issue.operand_b);
			default: logic_res = '0;
		endcase
	end

	// value to shift is operand_b
	always_comb begin
		case (issue.op)
			mips_pkg::alu_sll: shift_res = issue.operand_b << sa;
			mips_pkg::alu_srl: shift_res = issue.operand_b >> sa;
			mips_pkg::alu_sra: shift_res = $signed(issue.operand_b) >>> sa;
			default: shift_res = '0;
		endcase
	end

	always_comb begin
		ovf = 1'b0;
		case (issue.op)
			mips_pkg::alu_add: begin
				arith_res = sum;
				ovf = (issue.operand_a[`MIPS_XLEN-1] == issue.operand_b[`MIPS_XLEN-1]) &&
					(sum[`MIPS_XLEN-1] != issue.operand_a[`MIPS_XLEN-1]);
			end
			mips_pkg::alu_addu: arith_res = sum;
			mips_pkg::alu_sub: begin
				arith_res = diff;
				ovf = (issue.operand_a[`MIPS_XLEN-1] != issue.operand_b[`MIPS_XLEN-1]) &&
					(diff[`MIPS_XLEN-1] != issue.operand_a[`MIPS_XLEN-1]);
			end
			mips_pkg::alu_subu: arith_res = diff;
			mips_pkg::alu_slt: begin
				arith_res = {{(`MIPS_XLEN-1){1'b0}},
					$signed(issue.operand_a) < $signed(issue.operand_b)};
			end
			mips_pkg::alu_sltu: begin
				arith_res = {{(`MIPS_XLEN-1){1'b0}}, issue.operand_a < issue.operand_b};
			end
			default: arith_res = '0;
		endcase
	end

	always_comb begin
		case (issue.sel)
			mips_pkg::sel_logic: result = logic_res;
			mips_pkg::sel_shift: result = shift_res;
			mips_pkg::sel_arith: result = arith_res;
			default: result = '0;
		endcase
	end

	// overflowing add/sub writes nothing
	assign ex_fwd_valid_o = issue.valid && issue.write_en && !ovf;
	assign ex_fwd_addr_o = issue.dest;
	assign ex_fwd_data_o = result;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= ex_fwd_valid_o;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr_o <= ex_fwd_addr_o;
		wb_data_o <= ex_fwd_data_o;
	end

	assert property (@(posedge clk) disable iff (reset_i)
		wb_valid_o |-> $past(issue.valid && issue.write_en))
		else $error("write-back without a preceding writing issue");

endmodule

`default_nettype wire

// File: mips_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_result (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic wb_valid_i,
	input mips_pkg::reg_addr_t wb_addr_i,
	input mips_pkg::word_t wb_data_i,
	reg_read_if.file rd_port
);

	mips_pkg::word_t regs [`MIPS_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid_i && wb_addr_i != '0) begin
			regs[wb_addr_i] <= wb_data_i;
		end
	end

	// reg 0 hardwired to zero
	assign rd_port.data_a = (rd_port.addr_a == '0) ? '0 : regs[rd_port.addr_a];
	assign rd_port.data_b = (rd_port.addr_b == '0) ? '0 : regs[rd_port.addr_b];

	// decode already drops writes to reg 0
	assert property (@(posedge clk) disable iff (reset_i)
		wb_valid_i |-> wb_addr_i != '0)
		else $error("write-back targets register 0");

endmodule

`default_nettype wire

// File: mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic inst_valid_i,
	input mips_pkg::instr_u inst_i,
	output logic result_valid_o,
	output mips_pkg::reg_addr_t result_addr_o,
	output mips_pkg::word_t result_data_o
);

	logic ex_fwd_valid;
	mips_pkg::reg_addr_t ex_fwd_addr;
	mips_pkg::word_t ex_fwd_data;
	logic wb_valid;
	mips_pkg::reg_addr_t wb_addr;
	mips_pkg::word_t wb_data;

	issue_if issue0 ();
	reg_read_if rd0 ();

	mips_decode decode0 (
		.clk(clk),
		.reset_i(reset_i),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.rd_port(rd0.reader),
		.ex_fwd_valid_i(ex_fwd_valid),
		.ex_fwd_addr_i(ex_fwd_addr),
		.ex_fwd_data_i(ex_fwd_data),
		.wb_valid_i(wb_valid),
		.wb_addr_i(wb_addr),
		.wb_data_i(wb_data),
		.issue(issue0.issuer)
	);

	mips_execute execute0 (
		.clk(clk),
		.reset_i(reset_i),
		.issue(issue0.executor),
		.ex_fwd_valid_o(ex_fwd_valid),
		.ex_fwd_addr_o(ex_fwd_addr),
		.ex_fwd_data_o(ex_fwd_data),
		.wb_valid_o(wb_valid),
		.wb_addr_o(wb_addr),
		.wb_data_o(wb_data)
	);

	mips_result result0 (
		.clk(clk),
		.reset_i(reset_i),
		.wb_valid_i(wb_valid),
		.wb_addr_i(wb_addr),
		.wb_data_i(wb_data),
		.rd_port(rd0.file)
	);

	// registered result is also the visible output
	assign result_valid_o = wb_valid;
	assign result_addr_o = wb_addr;
	assign result_data_o = wb_data;

endmodule

`default_nettype wire

// File: tb_mips_tasks.svh
function automatic logic [31:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// asm order: rd, rs, rt
function automatic mips_pkg::instr_u rtype(input mips_pkg::funct_e fn, input int rd,
		input int rs, input int rt, input int sa);
	mips_pkg::instr_u w;
	w.r_fields.opcode = mips_pkg::op_special;
	w.r_fields.rs = mips_pkg::reg_addr_t'(rs);
	w.r_fields.rt = mips_pkg::reg_addr_t'(rt);
	w.r_fields.rd = mips_pkg::reg_addr_t'(rd);
	w.r_fields.shamt = 5'(sa);
	w.r_fields.funct = fn;
	return w;
endfunction

function automatic mips_pkg::instr_u itype(input mips_pkg::opcode_e op, input int rt,
		input int rs, input logic [15:0] imm);
	mips_pkg::instr_u w;
	w.i_fields.opcode = op;
	w.i_fields.rs = mips_pkg::reg_addr_t'(rs);
	w.i_fields.rt = mips_pkg::reg_addr_t'(rt);
	w.i_fields.imm16 = imm;
	return w;
endfunction

// sequential MIPS semantics, commits to the model
function automatic void predict(input mips_pkg::instr_u ins, output logic has,
		output mips_pkg::reg_addr_t dst, output mips_pkg::word_t val);
	mips_pkg::word_t a;
	mips_pkg::word_t b;
	mips_pkg::word_t simm;
	logic signed [32:0] wide;
	a = model[ins.i_fields.rs];
	b = model[ins.i_fields.rt];
	simm = {{16{ins.i_fields.imm16[15]}}, ins.i_fields.imm16};
	has = 1'b1;
	dst = ins.i_fields.rt;
	val = '0;
	case (ins.i_fields.opcode)
		mips_pkg::op_special: begin
			dst = ins.r_fields.rd;
			case (ins.r_fields.funct)
				mips_pkg::fn_sll: val = b << ins.r_fields.shamt;
				mips_pkg::fn_srl: val = b >> ins.r_fields.shamt;
				mips_pkg::fn_sra: val = $signed(b) >>> ins.r_fields.shamt;
				mips_pkg::fn_sllv: val = b << a[4:0];
				mips_pkg::fn_srlv: val = b >> a[4:0];
				mips_pkg::fn_srav: val = $signed(b) >>> a[4:0];
				mips_pkg::fn_add: begin
					wide = {a[31], a} + {b[31], b};
					val = wide[31:0];
					has = (wide[32] == wide[31]); // no write on overflow
				end
				mips_pkg::fn_addu: val = a + b;
				mips_pkg::fn_sub: begin
					wide = {a[31], a} - {b[31], b};
					val = wide[31:0];
					has = (wide[32] == wide[31]);
				end
				mips_pkg::fn_subu: val = a - b;
				mips_pkg::fn_and: val = a & b;
				mips_pkg::fn_or: val = a | b;
				mips_pkg::fn_xor: val = a ^ b;
				mips_pkg::fn_nor: val = ~(a | b);
				mips_pkg::fn_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				mips_pkg::fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
				default: has = 1'b0;
			endcase
		end
		mips_pkg::op_ori: val = a | {16'h0, ins.i_fields.imm16};
		mips_pkg::op_andi: val = a & {16'h0, ins.i_fields.imm16};
		mips_pkg::op_xori: val = a ^ {16'h0, ins.i_fields.imm16};
		mips_pkg::op_lui: val = {ins.i_fields.imm16, 16'h0};
		mips_pkg::op_addi: begin
			wide = {a[31], a} + {simm[31], simm};
			val = wide[31:0];
			has = (wide[32] == wide[31]);
		end
		mips_pkg::op_addiu: val = a + simm;
		mips_pkg::op_slti: val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
		mips_pkg::op_sltiu: val = (a < simm) ? 32'd1 : 32'd0;
		default: has = 1'b0;
	endcase
	if (dst == '0) begin
		has = 1'b0;
	end
	if (has) begin
		model[dst] = val;
	end
endfunction

task automatic check_result(input mips_pkg::reg_addr_t exp_addr,
		input mips_pkg::word_t exp_data);
	if (result_valid_o !== 1'b1) begin
		pulse_errs++;
		$display("missing result pulse at %0t, expected a write to r%0d", $time, exp_addr);
	end else if (result_addr_o !== exp_addr || result_data_o !== exp_data) begin
		value_errs++;
		$display("[ERROR] %0t: got r%0d = %h, expected r%0d = %h", $time,
			result_addr_o, result_data_o, exp_addr, exp_data);
	end
endtask

task automatic check_quiet();
	if (result_valid_o !== 1'b0) begin
		pulse_errs++;
		$display("unexpected result pulse at %0t, r%0d = %h", $time,
			result_addr_o, result_data_o);
	end
endtask

task automatic send(input mips_pkg::instr_u ins);
	expect_t e;
	@(posedge clk);
	inst_valid_i <= 1'b1;
	inst_i <= ins;
	e.due = cycle + 3; // sampled at edge k, visible after k+1
	predict(ins, e.has, e.addr, e.data);
	expq.push_back(e);
endtask

task automatic idle(input int n);
	repeat (n) begin
		@(posedge clk);
		inst_valid_i <= 1'b0;
		inst_i <= mips_pkg::instr_u'(next_rand()); // junk, must be ignored
	end
endtask

task automatic test_reset();
	reset_i <= 1'b1;
	repeat (16) @(posedge clk);
	reset_i <= 1'b0;
	idle(4);
endtask

task automatic test_immediates();
	send(itype(mips_pkg::op_ori, 1, 0, 16'h1234));
	idle(3);
	send(itype(mips_pkg::op_andi, 2, 1, 16'h0ff0));
	idle(3);
	send(itype(mips_pkg::op_xori, 3, 1, 16'hffff));
	idle(3);
	send(itype(mips_pkg::op_lui, 4, 0, 16'h8765));
	idle(3);
	send(itype(mips_pkg::op_addiu, 5, 4, 16'h8001)); // negative imm
	idle(3);
	send(itype(mips_pkg::op_slti, 6, 4, 16'h0001));
	idle(3);
	send(itype(mips_pkg::op_sltiu, 7, 1, 16'hffff));
	idle(3);
endtask

task automatic test_forwarding();
	send(rtype(mips_pkg::fn_addu, 8, 1, 4, 0));
	send(rtype(mips_pkg::fn_add, 9, 8, 1, 0));
	send(rtype(mips_pkg::fn_sub, 10, 8, 9, 0)); // r8 from wb, r9 from ex
	send(rtype(mips_pkg::fn_xor, 11, 10, 8, 0));
	send(rtype(mips_pkg::fn_or, 12, 9, 10, 0));
	send(rtype(mips_pkg::fn_nor, 13, 12, 11, 0));
	// same register in ex and wb, ex must win
	repeat (4) send(rtype(mips_pkg::fn_addu, 13, 13, 13, 0));
	send(rtype(mips_pkg::fn_slt, 14, 13, 8, 0));
	send(rtype(mips_pkg::fn_sltu, 15, 13, 14, 0));
	send(rtype(mips_pkg::fn_subu, 14, 15, 13, 0));
	send(rtype(mips_pkg::fn_and, 15, 14, 12, 0));
	idle(4);
endtask

task automatic test_shifts();
	send(itype(mips_pkg::op_lui, 16, 0, 16'h8000));
	send(itype(mips_pkg::op_ori, 16, 16, 16'h1234));
	send(itype(mips_pkg::op_ori, 17, 0, 16'h0007));
	send(itype(mips_pkg::op_ori, 18, 0, 16'h0023)); // only low 5 bits count
	send(rtype(mips_pkg::fn_sll, 19, 0, 16, 4));
	send(rtype(mips_pkg::fn_srl, 19, 0, 16, 4));
	send(rtype(mips_pkg::fn_sra, 19, 0, 16, 31));
	send(rtype(mips_pkg::fn_sllv, 20, 17, 16, 0));
	send(rtype(mips_pkg::fn_srlv, 20, 18, 16, 0));
	send(rtype(mips_pkg::fn_srav, 20, 17, 16, 0));
	send(rtype(mips_pkg::fn_srav, 20, 18, 19, 0));
	idle(4);
endtask

task automatic test_suppressed();
	send(itype(mips_pkg::op_lui, 21, 0, 16'h7fff));
	send(itype(mips_pkg::op_ori, 21, 21, 16'hffff));
	send(itype(mips_pkg::op_ori, 22, 0, 16'h0055)); // old value to keep
	send(rtype(mips_pkg::fn_add, 22, 21, 21, 0));
	send(itype(mips_pkg::op_addi, 22, 21, 16'h0001));
	send(itype(mips_pkg::op_lui, 23, 0, 16'h8000));
	send(rtype(mips_pkg::fn_sub, 22, 23, 17, 0));
	send(itype(mips_pkg::op_ori, 0, 17, 16'h0005));
	send(rtype(mips_pkg::fn_addu, 0, 17, 17, 0));
	send(itype(mips_pkg::opcode_e'(6'h23), 22, 1, 16'h0004)); // a load word
	send(rtype(mips_pkg::funct_e'(6'h18), 22, 1, 2, 0));
	send(rtype(mips_pkg::fn_or, 24, 22, 0, 0));
	send(rtype(mips_pkg::fn_or, 25, 0, 0, 0));
	send(rtype(mips_pkg::fn_addu, 26, 0, 17, 0));
	idle(4);
endtask

task automatic test_random();
	logic [31:0] r;
	logic [31:0] r2;
	int k;
	repeat (random_count) begin
		r = next_rand();
		r2 = next_rand();
		k = r[31:24] % 24;
		if (k < 16) begin
			send(rtype(fn_list[k], r[14:10], r[4:0], r[9:5], r[19:15]));
		end else begin
			send(itype(op_list[k - 16], r[9:5], r[4:0], r2[15:0]));
		end
	end
	idle(4);
endtask

// File: tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

	localparam int clk_period = 4;
	localparam int directed_count = 46;
	localparam int random_count = 200;

	typedef struct {
		int due; // negedge count when the pulse is sampled
		logic has;
		mips_pkg::reg_addr_t addr;
		mips_pkg::word_t data;
	} expect_t;

	logic clk = 1'b0;
	logic reset_i;
	logic inst_valid_i;
	mips_pkg::instr_u inst_i;
	logic result_valid_o;
	mips_pkg::reg_addr_t result_addr_o;
	mips_pkg::word_t result_data_o;

	mips_pkg::word_t model [32]; // architectural register state
	expect_t expq [$];
	expect_t head;
	int cycle = 0;
	int value_errs = 0;
	int pulse_errs = 0;
	logic [31:0] rng_state = 32'hdf97;

	mips_pkg::funct_e fn_list [16] = '{mips_pkg::fn_sll, mips_pkg::fn_srl,
		mips_pkg::fn_sra, mips_pkg::fn_sllv, mips_pkg::fn_srlv, mips_pkg::fn_srav,
		mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub, mips_pkg::fn_subu,
		mips_pkg::fn_and, mips_pkg::fn_or, mips_pkg::fn_xor, mips_pkg::fn_nor,
		mips_pkg::fn_slt, mips_pkg::fn_sltu};
	mips_pkg::opcode_e op_list [8] = '{mips_pkg::op_ori, mips_pkg::op_andi,
		mips_pkg::op_xori, mips_pkg::op_lui, mips_pkg::op_addi, mips_pkg::op_addiu,
		mips_pkg::op_slti, mips_pkg::op_sltiu};

	mips_core dut0 (
		.clk(clk),
		.reset_i(reset_i),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.result_valid_o(result_valid_o),
		.result_addr_o(result_addr_o),
		.result_data_o(result_data_o)
	);

	always #(clk_period / 2) clk = ~clk;

	`include "tb_mips_tasks.svh"

	// outputs settle after posedge, so look at them on the falling edge
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (expq.size() > 0 && expq[0].due == cycle) begin
			head = expq.pop_front();
			if (head.has) begin
				check_result(head.addr, head.data);
			end else begin
				check_quiet();
			end
		end else begin
			check_quiet();
		end
	end

	initial begin
		#(((directed_count + random_count) * 4 + 200 + 16) * clk_period);
		$display("timeout: the test sequence did not finish in time");
		$display("Test failures found");
		$finish;
	end

	initial begin
		reset_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		foreach (model[i]) begin
			model[i] = '0;
		end
		test_reset();
		test_immediates();
		test_forwarding();
		test_shifts();
		test_suppressed();
		test_random();
		idle(6);
		if (expq.size() != 0) begin
			pulse_errs++;
			$display("%0d expected results were never seen", expq.size());
		end
		$display("errors: %0d wrong values, %0d missing or extra pulses",
			value_errs, pulse_errs);
		if (value_errs + pulse_errs == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
mips_pkg.sv
mips_if.sv
mips_decode.sv
mips_execute.sv
mips_result.sv
mips_core.sv
tb_mips_core.sv
